// File: hdl/zip_dbg_bus_pkg.sv
// Debug AXI-lite bus package
// Bus widths and the word address split
// Register index and control word select
// Response code and the W channel beat type

package zip_dbg_bus_pkg;

	// Bus geometry
	localparam int DBG_ADDR_WIDTH = 8;
	localparam int DBG_DATA_WIDTH = 32;
	// Byte offset bits below the word address
	localparam int DBG_LSB = 2;

	// Word address map
	// Bit 5 picks the control word over a core register
	localparam int CTRL_SEL_BIT = 5;
	localparam int REG_IDX_WIDTH = 5;

	// Only response this slave ever gives
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef logic [DBG_ADDR_WIDTH-DBG_LSB-1:0] dbg_word_addr_t;
	typedef logic [REG_IDX_WIDTH-1:0] dbg_reg_idx_t;

	// Data and strobe travel as one skid payload
	typedef struct packed {
		logic [DBG_DATA_WIDTH-1:0]   data;
		logic [DBG_DATA_WIDTH/8-1:0] strb;
	} dbg_wbeat_t;

endpackage

// File: hdl/zip_dbg_ctl_pkg.sv
// Run control package
// Control word command bits
// Power-up reset hold length and start state
// Status word bit layout
// Reset hold counter type

package zip_dbg_ctl_pkg;

	//////////////////////////////
	// Control word
	//////////////////////////////

	// Byte 0 carries the reset request
	localparam int RESET_BIT = 6;
	// Byte 1 carries step, halt and clear cache
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Cycles of reset after all reset sources let go
	localparam int RESET_DURATION = 10;
	// Core runs out of reset
	localparam logic START_HALTED = 1'b0;

	//////////////////////////////
	// Status word
	//////////////////////////////

	localparam int STAT_RESET = 6;
	// Interrupt shows up twice
	localparam int STAT_IRQ = 7;
	localparam int STAT_IRQ_HI = 16;
	// Set when the core is not stalled
	localparam int STAT_HALTED = 9;
	localparam int STAT_HALT = 10;
	// Three condition bits at 14..12
	localparam int STAT_CC_LSB = 12;
	localparam int STAT_BREAK = 15;

	// Counter must hold RESET_DURATION itself
	typedef logic [$clog2(RESET_DURATION+1)-1:0] reset_count_t;

endpackage

// File: hdl/dbg_skid_buffer.sv
// Valid/ready skid buffer
// Pass-through while the output side takes data
// One stored beat when the output stalls
// Payload type set by a type parameter

`timescale 1ns/1ps

module dbg_skid_buffer #(
	parameter type T = logic
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Upstream side
	input  logic i_valid,
	output logic o_ready,
	input  T     i_data,
	// Downstream side
	output logic o_valid,
	input  logic i_ready,
	output T     o_data
);

	// Captured beat
	logic r_valid;
	T     r_data;

	// Stored beat blocks the upstream side
	assign o_ready = !r_valid;

	// Skid register flag
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			// Beat arrives while the output stalls
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Payload only loads while the buffer is empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Stored beat goes out first
	assign o_valid = r_valid || i_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

// File: hdl/dbg_write_path.sv
// Debug bus write side
// AW and W skid buffers and the write acceptance
// Core register write strobe with index and data
// Control word hand-off and the B channel

`timescale 1ns/1ps

module dbg_write_path (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,
	// AW channel
	input  logic                          i_awvalid,
	output logic                          o_awready,
	input  logic [7:0]                    i_awaddr,
	// W channel
	input  logic                          i_wvalid,
	output logic                          o_wready,
	input  logic [31:0]                   i_wdata,
	input  logic [3:0]                    i_wstrb,
	// B channel
	output logic                          o_bvalid,
	input  logic                          i_bready,
	output logic [1:0]                    o_bresp,
	// Core debug write port
	input  logic                          i_core_stall,
	output logic                          o_core_we,
	output zip_dbg_bus_pkg::dbg_reg_idx_t o_core_wreg,
	output logic [31:0]                   o_core_wdata,
	// Pulses towards run control
	output logic                          o_reg_write,
	output logic                          o_ctl_write,
	output logic [31:0]                   o_ctl_data,
	output logic [3:0]                    o_ctl_strb
);

	zip_dbg_bus_pkg::dbg_word_addr_t aw_addr;
	zip_dbg_bus_pkg::dbg_wbeat_t     w_beat;
	zip_dbg_bus_pkg::dbg_wbeat_t     w_in;
	logic aw_valid, w_valid;
	logic write_ready, write_stall, ctl_sel, reg_go;

	//////////////////////////////
	// Skid buffers
	//////////////////////////////

	// Byte offset dropped here
	dbg_skid_buffer #(
		.T(zip_dbg_bus_pkg::dbg_word_addr_t)
	) aw_skid_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_awvalid),
		.o_ready      (o_awready),
		.i_data       (i_awaddr[zip_dbg_bus_pkg::DBG_ADDR_WIDTH-1:zip_dbg_bus_pkg::DBG_LSB]),
		.o_valid      (aw_valid),
		.i_ready      (write_ready),
		.o_data       (aw_addr)
	);

	assign w_in.data = i_wdata;
	assign w_in.strb = i_wstrb;

	dbg_skid_buffer #(
		.T(zip_dbg_bus_pkg::dbg_wbeat_t)
	) w_skid_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_wvalid),
		.o_ready      (o_wready),
		.i_data       (w_in),
		.o_valid      (w_valid),
		.i_ready      (write_ready),
		.o_data       (w_beat)
	);

	//////////////////////////////
	// Acceptance
	//////////////////////////////

	assign ctl_sel = aw_addr[zip_dbg_bus_pkg::CTRL_SEL_BIT];
	// Earlier core write still waiting on the core
	assign write_stall = o_core_we && i_core_stall;

	// Control and zero-strobe writes skip the core stall
	assign write_ready = aw_valid && w_valid
		&& ((w_beat.strb == '0) || ctl_sel || !write_stall)
		&& (!o_bvalid || i_bready);

	assign reg_go = write_ready && (|w_beat.strb) && !ctl_sel;
	assign o_reg_write = reg_go;

	// Control word goes on raw
	assign o_ctl_write = write_ready && ctl_sel;
	assign o_ctl_data = w_beat.data;
	assign o_ctl_strb = w_beat.strb;

	// Core write strobe held through the stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_core_we <= 1'b0;
		else if (!write_stall)
			o_core_we <= reg_go;
	end

	// Index and data frozen with the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			o_core_wreg <= aw_addr[zip_dbg_bus_pkg::REG_IDX_WIDTH-1:0];
			o_core_wdata <= w_beat.data;
		end
	end

	// B channel
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign o_bresp = zip_dbg_bus_pkg::RESP_OKAY;

endmodule

// File: hdl/dbg_read_path.sv
// Debug bus read side
// AR skid buffer and the read acceptance
// Pending flag for core register reads
// R channel loaded from the core or the status word

`timescale 1ns/1ps

module dbg_read_path (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,
	// AR channel
	input  logic                          i_arvalid,
	output logic                          o_arready,
	input  logic [7:0]                    i_araddr,
	// R channel
	output logic                          o_rvalid,
	input  logic                          i_rready,
	output logic [31:0]                   o_rdata,
	output logic [1:0]                    o_rresp,
	// Core read port and status
	output zip_dbg_bus_pkg::dbg_reg_idx_t o_core_rreg,
	input  logic [31:0]                   i_core_rdata,
	input  logic [31:0]                   i_status
);

	zip_dbg_bus_pkg::dbg_word_addr_t ar_addr;
	logic ar_valid, read_ready, read_pending, status_sel;

	dbg_skid_buffer #(
		.T(zip_dbg_bus_pkg::dbg_word_addr_t)
	) ar_skid_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (i_arvalid),
		.o_ready      (o_arready),
		.i_data       (i_araddr[zip_dbg_bus_pkg::DBG_ADDR_WIDTH-1:zip_dbg_bus_pkg::DBG_LSB]),
		.o_valid      (ar_valid),
		.i_ready      (read_ready),
		.o_data       (ar_addr)
	);

	// Control word address reads back the status word
	assign status_sel = ar_addr[zip_dbg_bus_pkg::CTRL_SEL_BIT];

	// One read in flight and R must be free
	assign read_ready = ar_valid && !read_pending && (!o_rvalid || i_rready);

	// Core sees the index straight from the skid output
	assign o_core_rreg = ar_addr[zip_dbg_bus_pkg::REG_IDX_WIDTH-1:0];

	// Core answers one cycle after the index
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			read_pending <= 1'b0;
		else
			read_pending <= read_ready && !status_sel;
	end

	// Status answers at once and register reads a cycle later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && status_sel) || read_pending;
	end

	// Data only moves while R is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= read_pending ? i_core_rdata : i_status;
	end

	assign o_rresp = zip_dbg_bus_pkg::RESP_OKAY;

endmodule

// File: hdl/cpu_run_control.sv
// CPU run control
// Power-up and external reset hold
// Halt, single step and clear cache commands
// Status word assembly

`timescale 1ns/1ps

module cpu_run_control (
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,
	input  logic        i_cpu_reset,
	input  logic        i_interrupt,
	// Write side events
	input  logic        i_reg_write,
	input  logic        i_ctl_write,
	input  logic [31:0] i_ctl_data,
	input  logic [3:0]  i_ctl_strb,
	// Core debug state
	input  logic        i_core_we,
	input  logic        i_core_stall,
	input  logic        i_core_break,
	input  logic [2:0]  i_core_cc,
	// Commands to the core
	output logic        o_cmd_reset,
	output logic        o_cmd_halt,
	output logic        o_cmd_step,
	output logic        o_cmd_clear_cache,
	output logic [31:0] o_status
);

	zip_dbg_ctl_pkg::reset_count_t reset_counter;
	logic reset_hold;
	logic run_byte, write_stall;

	// Byte 1 holds step, halt and clear cache
	assign run_byte = i_ctl_write && i_ctl_strb[1];
	// Register write still pending at the core
	assign write_stall = i_core_we && i_core_stall;

	//////////////////////////////
	// Reset hold
	//////////////////////////////

	// Reloads on every reset source
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_counter <= zip_dbg_ctl_pkg::reset_count_t'(zip_dbg_ctl_pkg::RESET_DURATION);
		else if (reset_counter > 0)
			reset_counter <= reset_counter - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_hold <= 1'b1;
		else
			reset_hold <= (reset_counter > 1);
	end

	// Break restarts a free-running core
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_reset <= 1'b1;
		else if (reset_hold)
			o_cmd_reset <= 1'b1;
		else if (i_core_break && !zip_dbg_ctl_pkg::START_HALTED)
			o_cmd_reset <= 1'b1;
		else
			// One-cycle pulse from byte 0
			o_cmd_reset <= i_ctl_write && i_ctl_strb[0]
				&& i_ctl_data[zip_dbg_ctl_pkg::RESET_BIT];
	end

	//////////////////////////////
	// Halt
	//////////////////////////////

	// Later checks win over the release
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cmd_halt <= zip_dbg_ctl_pkg::START_HALTED;
		else if (i_cpu_reset && !i_reg_write && !write_stall)
			o_cmd_halt <= zip_dbg_ctl_pkg::START_HALTED;
		else if (o_cmd_reset && zip_dbg_ctl_pkg::START_HALTED)
			o_cmd_halt <= zip_dbg_ctl_pkg::START_HALTED;
		else
		begin
			// Release on a clear-halt or step, core idle
			if (!i_core_we && !i_core_stall && run_byte
				&& (!i_ctl_data[zip_dbg_ctl_pkg::HALT_BIT]
				|| i_ctl_data[zip_dbg_ctl_pkg::STEP_BIT]))
				o_cmd_halt <= 1'b0;
			// Break parks a core that starts halted
			if (i_core_break && zip_dbg_ctl_pkg::START_HALTED)
				o_cmd_halt <= 1'b1;
			// Plain halt request
			if (run_byte && i_ctl_data[zip_dbg_ctl_pkg::HALT_BIT]
				&& !i_ctl_data[zip_dbg_ctl_pkg::STEP_BIT])
				o_cmd_halt <= 1'b1;
			// Register writes need a stopped core
			if (i_reg_write)
				o_cmd_halt <= 1'b1;
			// Step runs one instruction then stops
			if (o_cmd_step)
				o_cmd_halt <= 1'b1;
			if (o_cmd_clear_cache)
				o_cmd_halt <= 1'b1;
			if (run_byte && i_ctl_data[zip_dbg_ctl_pkg::CLEAR_CACHE_BIT])
				o_cmd_halt <= 1'b1;
		end
	end

	// Step pulse lasts until the core moves
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_step <= 1'b0;
		else if (run_byte && i_ctl_data[zip_dbg_ctl_pkg::STEP_BIT])
			o_cmd_step <= 1'b1;
		else if (!i_core_stall)
			o_cmd_step <= 1'b0;
	end

	// Clear cache only together with halt
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cmd_reset)
			o_cmd_clear_cache <= 1'b0;
		else if (run_byte && i_ctl_data[zip_dbg_ctl_pkg::CLEAR_CACHE_BIT]
			&& i_ctl_data[zip_dbg_ctl_pkg::HALT_BIT])
			o_cmd_clear_cache <= 1'b1;
		else if (o_cmd_halt && !i_core_stall)
			o_cmd_clear_cache <= 1'b0;
	end

	//////////////////////////////
	// Status word
	//////////////////////////////

	always_comb
	begin
		o_status = '0;
		o_status[zip_dbg_ctl_pkg::STAT_RESET] = o_cmd_reset;
		o_status[zip_dbg_ctl_pkg::STAT_IRQ] = i_interrupt;
		o_status[zip_dbg_ctl_pkg::STAT_HALTED] = !i_core_stall;
		o_status[zip_dbg_ctl_pkg::STAT_HALT] = o_cmd_halt;
		o_status[zip_dbg_ctl_pkg::STAT_CC_LSB +: 3] = i_core_cc;
		o_status[zip_dbg_ctl_pkg::STAT_BREAK] = i_core_break;
		o_status[zip_dbg_ctl_pkg::STAT_IRQ_HI] = i_interrupt;
	end

endmodule

// File: hdl/zip_dbg_top.sv
// Debug slave top level
// Write path feeding run control
// Read path returning core registers or status
// Core debug port brought out to the pins

`timescale 1ns/1ps

module zip_dbg_top (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,
	// Debug bus
	input  logic                          i_dbg_awvalid,
	output logic                          o_dbg_awready,
	input  logic [7:0]                    i_dbg_awaddr,
	input  logic                          i_dbg_wvalid,
	output logic                          o_dbg_wready,
	input  logic [31:0]                   i_dbg_wdata,
	input  logic [3:0]                    i_dbg_wstrb,
	output logic                          o_dbg_bvalid,
	input  logic                          i_dbg_bready,
	output logic [1:0]                    o_dbg_bresp,
	input  logic                          i_dbg_arvalid,
	output logic                          o_dbg_arready,
	input  logic [7:0]                    i_dbg_araddr,
	output logic                          o_dbg_rvalid,
	input  logic                          i_dbg_rready,
	output logic [31:0]                   o_dbg_rdata,
	output logic [1:0]                    o_dbg_rresp,
	// System inputs
	input  logic                          i_cpu_reset,
	input  logic                          i_interrupt,
	// Core debug port
	input  logic                          i_core_stall,
	input  logic                          i_core_break,
	input  logic [2:0]                    i_core_cc,
	input  logic [31:0]                   i_core_rdata,
	output logic                          o_core_we,
	output zip_dbg_bus_pkg::dbg_reg_idx_t o_core_wreg,
	output logic [31:0]                   o_core_wdata,
	output zip_dbg_bus_pkg::dbg_reg_idx_t o_core_rreg,
	// Run commands
	output logic                          o_cmd_reset,
	output logic                          o_cmd_halt,
	output logic                          o_cmd_step,
	output logic                          o_cmd_clear_cache
);

	logic        reg_write, ctl_write;
	logic [31:0] ctl_data, status;
	logic [3:0]  ctl_strb;

	dbg_write_path write_path_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid    (i_dbg_awvalid),
		.o_awready    (o_dbg_awready),
		.i_awaddr     (i_dbg_awaddr),
		.i_wvalid     (i_dbg_wvalid),
		.o_wready     (o_dbg_wready),
		.i_wdata      (i_dbg_wdata),
		.i_wstrb      (i_dbg_wstrb),
		.o_bvalid     (o_dbg_bvalid),
		.i_bready     (i_dbg_bready),
		.o_bresp      (o_dbg_bresp),
		.i_core_stall (i_core_stall),
		.o_core_we    (o_core_we),
		.o_core_wreg  (o_core_wreg),
		.o_core_wdata (o_core_wdata),
		.o_reg_write  (reg_write),
		.o_ctl_write  (ctl_write),
		.o_ctl_data   (ctl_data),
		.o_ctl_strb   (ctl_strb)
	);

	// Commands and status
	cpu_run_control run_control_i (
		.S_AXI_ACLK       (S_AXI_ACLK),
		.S_AXI_ARESETN    (S_AXI_ARESETN),
		.i_cpu_reset      (i_cpu_reset),
		.i_interrupt      (i_interrupt),
		.i_reg_write      (reg_write),
		.i_ctl_write      (ctl_write),
		.i_ctl_data       (ctl_data),
		.i_ctl_strb       (ctl_strb),
		.i_core_we        (o_core_we),
		.i_core_stall     (i_core_stall),
		.i_core_break     (i_core_break),
		.i_core_cc        (i_core_cc),
		.o_cmd_reset      (o_cmd_reset),
		.o_cmd_halt       (o_cmd_halt),
		.o_cmd_step       (o_cmd_step),
		.o_cmd_clear_cache(o_cmd_clear_cache),
		.o_status         (status)
	);

	dbg_read_path read_path_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid    (i_dbg_arvalid),
		.o_arready    (o_dbg_arready),
		.i_araddr     (i_dbg_araddr),
		.o_rvalid     (o_dbg_rvalid),
		.i_rready     (i_dbg_rready),
		.o_rdata      (o_dbg_rdata),
		.o_rresp      (o_dbg_rresp),
		.o_core_rreg  (o_core_rreg),
		.i_core_rdata (i_core_rdata),
		.i_status     (status)
	);

endmodule

// File: dv/zip_dbg_properties.sv
// Bound assertions for the debug slave
// B and R channel hold rules
// Core write strobe blocked during reset
// Register values right after reset

`timescale 1ns/1ps

module zip_dbg_properties (
	input logic        S_AXI_ACLK,
	input logic        S_AXI_ARESETN,
	input logic        i_bvalid,
	input logic        i_bready,
	input logic        i_rvalid,
	input logic        i_rready,
	input logic [31:0] i_rdata,
	input logic        i_core_we,
	input logic        i_cmd_reset,
	input logic        i_cmd_halt,
	input logic        i_cmd_step,
	input logic        i_cmd_clear_cache
);

	// Failure tally read by the testbench
	int fail_count = 0;

	//////////////////////////////
	// Response channels
	//////////////////////////////

	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid && !i_bready |=> i_bvalid)
		else begin fail_count++; $error("B valid dropped before its handshake"); end

	// Data frozen too
	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
		else begin fail_count++; $error("R valid or R data moved before its handshake"); end

	//////////////////////////////
	// Core side and reset
	//////////////////////////////

	// No register write into a core held in reset
	we_in_reset: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_cmd_reset |-> !i_core_we)
		else begin fail_count++; $error("Core write strobe high during reset command"); end

	reset_values: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !i_bvalid && !i_rvalid && !i_core_we && !i_cmd_step
		&& !i_cmd_clear_cache && i_cmd_reset
		&& (i_cmd_halt == zip_dbg_ctl_pkg::START_HALTED))
		else begin fail_count++; $error("Wrong output value after reset"); end

endmodule

bind zip_dbg_top zip_dbg_properties props_i (
	.S_AXI_ACLK       (S_AXI_ACLK),
	.S_AXI_ARESETN    (S_AXI_ARESETN),
	.i_bvalid         (o_dbg_bvalid),
	.i_bready         (i_dbg_bready),
	.i_rvalid         (o_dbg_rvalid),
	.i_rready         (i_dbg_rready),
	.i_rdata          (o_dbg_rdata),
	.i_core_we        (o_core_we),
	.i_cmd_reset      (o_cmd_reset),
	.i_cmd_halt       (o_cmd_halt),
	.i_cmd_step       (o_cmd_step),
	.i_cmd_clear_cache(o_cmd_clear_cache)
);

// File: dv/zip_dbg_tb.sv
// Testbench for the debug slave
// Clock, reset, core model and bus driver tasks
// Directed command tests and a random back-pressure run
// Scoreboards, error counts and watchdog

`timescale 1ns/1ps

module zip_dbg_tb;

	localparam int DIRECTED_TRANS = 8;
	localparam int RANDOM_TRANS = 24;
	// Word address 0x20 is the control word
	localparam logic [7:0] CTRL_ADDR = 8'h80;

	logic S_AXI_ACLK, S_AXI_ARESETN;
	logic i_dbg_awvalid, o_dbg_awready, i_dbg_wvalid, o_dbg_wready;
	logic i_dbg_arvalid, o_dbg_arready, o_dbg_bvalid, i_dbg_bready;
	logic o_dbg_rvalid, i_dbg_rready;
	logic [7:0]  i_dbg_awaddr, i_dbg_araddr;
	logic [31:0] i_dbg_wdata, o_dbg_rdata, i_core_rdata, o_core_wdata;
	logic [3:0]  i_dbg_wstrb;
	logic [1:0]  o_dbg_bresp, o_dbg_rresp;
	logic [2:0]  i_core_cc;
	logic i_cpu_reset, i_interrupt, i_core_stall, i_core_break, o_core_we;
	logic o_cmd_reset, o_cmd_halt, o_cmd_step, o_cmd_clear_cache;
	zip_dbg_bus_pkg::dbg_reg_idx_t o_core_wreg, o_core_rreg, rreg_seen, idx;

	// Scoreboards for read data and for {index, data} of core writes
	logic [31:0] read_q[$];
	logic [36:0] wr_q[$];
	logic [36:0] exp_wr;
	logic [31:0] data;
	logic        core_take, random_bp;
	integer      seed;
	int errors, checks, b_count, r_count, writes_sent, reads_sent;
	int step_cycles, cc_cycles, rst_cycles, stall_left;
	// Pre-drawn random traffic
	logic [7:0]  t_addr[RANDOM_TRANS];
	logic [31:0] t_data[RANDOM_TRANS];
	logic [3:0]  t_strb[RANDOM_TRANS];
	logic        t_write[RANDOM_TRANS];

	zip_dbg_top zip_dbg_top_i (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Register contents the core model answers with
	function automatic logic [31:0] core_value(input zip_dbg_bus_pkg::dbg_reg_idx_t ridx);
		return 32'h5A00_0000 + ridx * 32'h0001_0203;
	endfunction

	// Expected status for an idle core with no break and no reset
	function automatic logic [31:0] status_word(input logic irq, input logic halt,
		input logic [2:0] cc);
		logic [31:0] w;
		w = '0;
		w[zip_dbg_ctl_pkg::STAT_IRQ] = irq;
		w[zip_dbg_ctl_pkg::STAT_IRQ_HI] = irq;
		w[zip_dbg_ctl_pkg::STAT_HALTED] = 1'b1;
		w[zip_dbg_ctl_pkg::STAT_HALT] = halt;
		w[zip_dbg_ctl_pkg::STAT_CC_LSB +: 3] = cc;
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Ends 1 ns after a rising edge like every driver task
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb);
		logic aw_left, w_left, aw_hs, w_hs;
		if (strb != 0 && !addr[zip_dbg_bus_pkg::CTRL_SEL_BIT + zip_dbg_bus_pkg::DBG_LSB])
			wr_q.push_back({addr[6:2], wdata});
		writes_sent++;
		i_dbg_awaddr = addr;
		i_dbg_wdata = wdata;
		i_dbg_wstrb = strb;
		i_dbg_awvalid = 1'b1;
		i_dbg_wvalid = 1'b1;
		aw_left = 1'b1;
		w_left = 1'b1;
		while (aw_left || w_left)
		begin
			// Ready sampled mid-cycle for the handshake at the next edge
			@(negedge S_AXI_ACLK);
			aw_hs = aw_left && o_dbg_awready;
			w_hs = w_left && o_dbg_wready;
			wait_cycles(1);
			if (aw_hs)
			begin
				aw_left = 1'b0;
				i_dbg_awvalid = 1'b0;
			end
			if (w_hs)
			begin
				w_left = 1'b0;
				i_dbg_wvalid = 1'b0;
			end
		end
	endtask

	task automatic bus_read(input logic [7:0] addr, input logic [31:0] expected);
		logic ar_hs;
		read_q.push_back(expected);
		reads_sent++;
		i_dbg_araddr = addr;
		i_dbg_arvalid = 1'b1;
		ar_hs = 1'b0;
		while (!ar_hs)
		begin
			@(negedge S_AXI_ACLK);
			ar_hs = o_dbg_arready;
			wait_cycles(1);
		end
		i_dbg_arvalid = 1'b0;
	endtask

	// Count cycles of the reset command from the release on
	task automatic measure_reset_hold();
		rst_cycles = 0;
		wait_cycles(zip_dbg_ctl_pkg::RESET_DURATION + 4);
		check_value("reset hold cycles", rst_cycles, zip_dbg_ctl_pkg::RESET_DURATION + 1);
		check_value("o_cmd_reset", o_cmd_reset, 0);
		check_value("o_cmd_halt", o_cmd_halt, zip_dbg_ctl_pkg::START_HALTED);
	endtask

	//////////////////////////////
	// Monitors and core model
	//////////////////////////////

	always @(negedge S_AXI_ACLK)
	begin
		core_take = o_core_we && !i_core_stall;
		rreg_seen = o_core_rreg;
		if (o_cmd_step)
			step_cycles++;
		if (o_cmd_clear_cache)
			cc_cycles++;
		if (o_cmd_reset)
			rst_cycles++;
		// Core takes the write at the coming edge
		if (core_take && wr_q.size() == 0)
		begin
			errors++;
			$display("Core write strobe seen with no register write outstanding");
		end
		else if (core_take)
		begin
			exp_wr = wr_q.pop_front();
			check_value("o_core_wreg", o_core_wreg, exp_wr[36:32]);
			check_value("o_core_wdata", o_core_wdata, exp_wr[31:0]);
		end
		if (o_dbg_bvalid && i_dbg_bready)
		begin
			b_count++;
			check_value("o_dbg_bresp", o_dbg_bresp, zip_dbg_bus_pkg::RESP_OKAY);
		end
		if (o_dbg_rvalid && i_dbg_rready)
		begin
			r_count++;
			check_value("o_dbg_rresp", o_dbg_rresp, zip_dbg_bus_pkg::RESP_OKAY);
			if (read_q.size() == 0)
			begin
				errors++;
				$display("R response arrived with no read outstanding");
			end
			else
				check_value("o_dbg_rdata", o_dbg_rdata, read_q.pop_front());
		end
	end

	// Answers a cycle late and stalls two cycles per taken write
	always @(posedge S_AXI_ACLK)
	begin
		#1;
		i_core_rdata = core_value(rreg_seen);
		if (core_take)
			stall_left = 2;
		else if (stall_left > 0)
			stall_left--;
		i_core_stall = (stall_left != 0);
	end

	// Back-pressure stretches on B and R
	always @(posedge S_AXI_ACLK)
	begin
		#1;
		if (random_bp && ($random(seed) & 3) == 0)
			i_dbg_bready = !i_dbg_bready;
		if (random_bp && ($random(seed) & 3) == 0)
			i_dbg_rready = !i_dbg_rready;
	end

	initial
	begin
		repeat ((DIRECTED_TRANS + RANDOM_TRANS) * 20) @(posedge S_AXI_ACLK);
		$display("Watchdog expired before all transactions finished");
		$display("Something failed");
		$finish;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		seed = 4790;
		{i_dbg_awvalid, i_dbg_wvalid, i_dbg_arvalid, random_bp} = '0;
		{i_dbg_awaddr, i_dbg_araddr, i_dbg_wdata, i_dbg_wstrb} = '0;
		i_dbg_bready = 1'b1;
		i_dbg_rready = 1'b1;
		{i_cpu_reset, i_interrupt, i_core_stall, i_core_break, i_core_cc} = '0;
		i_core_rdata = '0;
		core_take = 1'b0;
		{errors, checks, b_count, r_count, writes_sent, reads_sent} = '0;
		{step_cycles, cc_cycles, rst_cycles, stall_left} = '0;
		S_AXI_ARESETN = 1'b0;
		repeat (3) @(posedge S_AXI_ACLK);
		#1 S_AXI_ARESETN = 1'b1;
		measure_reset_hold();
		// External CPU reset restarts the hold
		i_cpu_reset = 1'b1;
		wait_cycles(1);
		i_cpu_reset = 1'b0;
		measure_reset_hold();

		// Halt, step, clear cache and reset bit
		bus_write(CTRL_ADDR, 1 << zip_dbg_ctl_pkg::HALT_BIT, 4'b0010);
		wait_cycles(4);
		check_value("o_cmd_halt", o_cmd_halt, 1);
		step_cycles = 0;
		bus_write(CTRL_ADDR, (1 << zip_dbg_ctl_pkg::STEP_BIT)
			| (1 << zip_dbg_ctl_pkg::HALT_BIT), 4'b0010);
		wait_cycles(4);
		check_value("o_cmd_step cycles", step_cycles, 1);
		check_value("o_cmd_halt", o_cmd_halt, 1);
		cc_cycles = 0;
		bus_write(CTRL_ADDR, (1 << zip_dbg_ctl_pkg::CLEAR_CACHE_BIT)
			| (1 << zip_dbg_ctl_pkg::HALT_BIT), 4'b0010);
		wait_cycles(4);
		check_value("o_cmd_clear_cache cycles", cc_cycles, 1);
		rst_cycles = 0;
		bus_write(CTRL_ADDR, 1 << zip_dbg_ctl_pkg::RESET_BIT, 4'b0001);
		wait_cycles(4);
		check_value("o_cmd_reset cycles", rst_cycles, 1);

		// Release halt and let a register write halt the core again
		bus_write(CTRL_ADDR, 32'h0, 4'b0010);
		wait_cycles(4);
		check_value("o_cmd_halt", o_cmd_halt, 0);
		idx = $random(seed);
		data = $random(seed);
		bus_write({1'b0, idx, 2'b00}, data, 4'hF);
		@(negedge S_AXI_ACLK);
		check_value("o_core_we", o_core_we, 1);
		check_value("o_dbg_bvalid", o_dbg_bvalid, 1);
		check_value("o_cmd_halt", o_cmd_halt, 1);
		wait_cycles(4);

		// Register read answers in two cycles and status read in one
		idx = $random(seed);
		bus_read({1'b0, idx, 2'b00}, core_value(idx));
		@(negedge S_AXI_ACLK);
		check_value("o_dbg_rvalid", o_dbg_rvalid, 0);
		@(negedge S_AXI_ACLK);
		check_value("o_dbg_rvalid", o_dbg_rvalid, 1);
		i_interrupt = 1'b1;
		i_core_cc = $random(seed);
		wait_cycles(2);
		bus_read(CTRL_ADDR, status_word(1'b1, 1'b1, i_core_cc));
		@(negedge S_AXI_ACLK);
		check_value("o_dbg_rvalid", o_dbg_rvalid, 1);
		wait_cycles(2);

		// Random register traffic under back-pressure
		for (int i = 0; i < RANDOM_TRANS; i++)
		begin
			t_addr[i] = $random(seed) & 8'h7C;
			t_data[i] = $random(seed);
			t_strb[i] = $random(seed);
			t_write[i] = $random(seed) & 1;
			if (t_strb[i] == 0)
				t_strb[i] = 4'hF;
		end
		random_bp = 1'b1;
		for (int i = 0; i < RANDOM_TRANS; i++)
		begin
			if (t_write[i])
				bus_write(t_addr[i], t_data[i], t_strb[i]);
			else
				bus_read(t_addr[i], core_value(t_addr[i][6:2]));
		end
		wait (b_count == writes_sent && r_count == reads_sent);
		random_bp = 1'b0;
		wait_cycles(6);
		check_value("B responses", b_count, writes_sent);
		check_value("R responses", r_count, reads_sent);
		check_value("reads left", read_q.size(), 0);
		check_value("core writes left", wr_q.size(), 0);

		$display("Checks %0d, errors %0d, assertion failures %0d",
			checks, errors, zip_dbg_top_i.props_i.fail_count);
		if (errors == 0 && zip_dbg_top_i.props_i.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: Bender.yml
package:
  name: zip_dbg

sources:
  # Packages first, then the RTL from the leaves up
  - files:
      - hdl/zip_dbg_bus_pkg.sv
      - hdl/zip_dbg_ctl_pkg.sv
      - hdl/dbg_skid_buffer.sv
      - hdl/dbg_write_path.sv
      - hdl/dbg_read_path.sv
      - hdl/cpu_run_control.sv
      - hdl/zip_dbg_top.sv
  # Testbench with its bound assertions
  - target: test
    files:
      - dv/zip_dbg_properties.sv
      - dv/zip_dbg_tb.sv

// File: zip_dbg.f
hdl/zip_dbg_bus_pkg.sv
hdl/zip_dbg_ctl_pkg.sv
hdl/dbg_skid_buffer.sv
hdl/dbg_write_path.sv
hdl/dbg_read_path.sv
hdl/cpu_run_control.sv
hdl/zip_dbg_top.sv
dv/zip_dbg_properties.sv
dv/zip_dbg_tb.sv
